// ==== cad_cfg.svh ====
`ifndef CAD_CFG_SVH
`define CAD_CFG_SVH

// matrix counts
`define CAD_NUM_MATS   16

// ------------------------------
// dimensions
// ------------------------------
`define CAD_IMG_DIM    8
`define CAD_KER_DIM    5
`define CAD_CONV_DIM   4      // 8 - 5 + 1

// store depths
`define CAD_IMG_WORDS  1024   // 16 images x 64
`define CAD_KER_WORDS  400    // 16 kernels x 25

// serial length of one pooled result
`define CAD_OUT_BITS   20

`endif

// ==== cad_pkg.sv ====
package cad_pkg;

    // ------------------------------
    // data widths
    // ------------------------------
    typedef logic signed [7:0]  pixel_t;   // image pixel or kernel weight
    typedef logic signed [15:0] prod_t;    // 8 x 8 signed product
    typedef logic signed [19:0] sum_t;     // correlation sum or pooled max

    // store addresses
    typedef logic [9:0] img_addr_t;
    typedef logic [8:0] ker_addr_t;

    typedef logic [3:0] mat_idx_t;         // image or kernel number

    // controller states
    typedef enum logic [1:0]
    {
        IDLE,
        STORE,
        SELECT,
        FETCH
    } ctrl_state_e;

endpackage

// ==== cad_mem_if.sv ====
`timescale 1ns/1ps

interface cad_mem_if import cad_pkg::*; ();

    img_addr_t img_addr;
    ker_addr_t ker_addr;
    logic      img_we;
    logic      ker_we;
    logic      img_load;    // img_rdata holds a fetched pixel
    logic      ker_load;    // ker_rdata holds a fetched weight
    pixel_t    img_rdata;
    pixel_t    ker_rdata;

    modport ctrl
    (
        output img_addr, ker_addr, img_we, ker_we, img_load, ker_load
    );

    modport mem
    (
        input  img_addr, ker_addr, img_we, ker_we,
        output img_rdata, ker_rdata
    );

    // convolution side only sees fetched data
    modport sink
    (
        input img_rdata, ker_rdata, img_load, ker_load
    );

endinterface

// ==== cad_ctrl.sv ====
`timescale 1ns/1ps
`include "cad_cfg.svh"

module cad_ctrl import cad_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_in_valid,
    input  logic     i_in_valid2,
    input  mat_idx_t i_matrix_idx,
    output logic     o_conv_start,
    cad_mem_if.ctrl  mem
);

    localparam int IMG_PIX  = `CAD_IMG_DIM * `CAD_IMG_DIM;
    localparam int KER_PIX  = `CAD_KER_DIM * `CAD_KER_DIM;
    localparam int IN_TOTAL = `CAD_IMG_WORDS + `CAD_KER_WORDS;

    ctrl_state_e state, state_nxt;

    logic [10:0] in_cnt;       // byte position in the load stream
    logic [6:0]  fetch_cnt;
    logic        valid2_d;
    logic        load_act;
    logic        img_wr, ker_wr;
    mat_idx_t    img_idx, ker_idx;
    img_addr_t   rd_img_addr;
    ker_addr_t   rd_ker_addr;

    // ------------------------------
    // state machine
    // ------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:    state_nxt = i_in_valid ? STORE : (i_in_valid2 ? SELECT : IDLE);
            STORE:   state_nxt = i_in_valid ? STORE : IDLE;
            SELECT:  state_nxt = i_in_valid2 ? SELECT : FETCH;
            FETCH:   state_nxt = (fetch_cnt == 7'(IMG_PIX)) ? IDLE : FETCH;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // ------------------------------
    // load stream steering
    // ------------------------------
    assign load_act = i_in_valid && (state == IDLE || state == STORE);
    assign img_wr   = load_act && (in_cnt < 11'(`CAD_IMG_WORDS));
    assign ker_wr   = load_act && !img_wr && (in_cnt < 11'(IN_TOTAL));

    assign mem.img_we   = img_wr;
    assign mem.ker_we   = ker_wr;
    assign mem.img_addr = img_wr ? in_cnt[9:0] : rd_img_addr;
    assign mem.ker_addr = ker_wr ? ker_addr_t'(in_cnt - 11'(`CAD_IMG_WORDS)) : rd_ker_addr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            in_cnt <= '0;
        else
            in_cnt <= load_act ? in_cnt + 1'b1 : '0;
    end

    // first request cycle is the image, second the kernel
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid2_d <= 1'b0;
            img_idx  <= '0;
            ker_idx  <= '0;
        end
        else
        begin
            valid2_d <= i_in_valid2;
            if (i_in_valid2 && !valid2_d)
                img_idx <= i_matrix_idx;
            if (i_in_valid2 && valid2_d)
                ker_idx <= i_matrix_idx;
        end
    end

    // ------------------------------
    // fetch of the chosen pair
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fetch_cnt    <= '0;
            rd_img_addr  <= '0;
            rd_ker_addr  <= '0;
            mem.img_load <= 1'b0;
            mem.ker_load <= 1'b0;
            o_conv_start <= 1'b0;
        end
        else
        begin
            fetch_cnt <= (state == FETCH) ? fetch_cnt + 1'b1 : '0;
            if (state == SELECT && !i_in_valid2)
            begin
                rd_img_addr <= {img_idx, 6'b00_0000};            // idx << 6
                rd_ker_addr <= ker_addr_t'(ker_idx * KER_PIX);   // idx * 25
            end
            else if (state == FETCH)
            begin
                rd_img_addr <= rd_img_addr + 1'b1;
                if (fetch_cnt < 7'(KER_PIX - 1))
                    rd_ker_addr <= rd_ker_addr + 1'b1;   // hold on the last weight
            end
            // strobes trail the address by the read latency
            mem.img_load <= (state == FETCH) && (fetch_cnt < 7'(IMG_PIX));
            mem.ker_load <= (state == FETCH) && (fetch_cnt < 7'(KER_PIX));
            o_conv_start <= (state == FETCH) && (fetch_cnt == 7'(IMG_PIX));
        end
    end

endmodule

// ==== cad_store.sv ====
`timescale 1ns/1ps
`include "cad_cfg.svh"

module cad_store import cad_pkg::*;
(
    input  logic    clk,
    input  pixel_t  i_matrix,
    cad_mem_if.mem  mem
);

    pixel_t img_mem [0:`CAD_IMG_WORDS-1];
    pixel_t ker_mem [0:`CAD_KER_WORDS-1];

    // ------------------------------
    // image memory
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (mem.img_we)
            img_mem[mem.img_addr] <= i_matrix;
        mem.img_rdata <= img_mem[mem.img_addr];   // read data one cycle later
    end

    // ------------------------------
    // kernel memory
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (mem.ker_we)
            ker_mem[mem.ker_addr] <= i_matrix;
        mem.ker_rdata <= ker_mem[mem.ker_addr];
    end

endmodule

// ==== cad_conv.sv ====
`timescale 1ns/1ps
`include "cad_cfg.svh"

module cad_conv import cad_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_conv_start,
    output sum_t     o_sum,
    output logic     o_sum_valid,
    cad_mem_if.sink  mem
);

    localparam int ID      = `CAD_IMG_DIM;
    localparam int KD      = `CAD_KER_DIM;
    localparam int IMG_PIX = ID * ID;
    localparam int KER_PIX = KD * KD;
    localparam int POS_NUM = `CAD_CONV_DIM * `CAD_CONV_DIM;

    pixel_t     win  [0:IMG_PIX-1];   // whole image, row-major
    pixel_t     ker  [0:KER_PIX-1];
    prod_t      prod [0:KER_PIX-1];
    logic [3:0] pos;                  // window origin, row-major
    logic [1:0] pos_m, pos_n;
    logic       pos_act;
    logic       mul_vld;
    sum_t       acc;

    // ------------------------------
    // operand buffers
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (mem.img_load)
        begin
            for (int k = 0; k < IMG_PIX - 1; k++)
                win[k] <= win[k + 1];
            win[IMG_PIX-1] <= mem.img_rdata;   // newest pixel enters at the end
        end
        if (mem.ker_load)
        begin
            for (int k = 0; k < KER_PIX - 1; k++)
                ker[k] <= ker[k + 1];
            ker[KER_PIX-1] <= mem.ker_rdata;
        end
    end

    // ------------------------------
    // position walk and valid pipe
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pos         <= '0;
            pos_act     <= 1'b0;
            mul_vld     <= 1'b0;
            o_sum_valid <= 1'b0;
        end
        else
        begin
            if (i_conv_start)
            begin
                pos     <= '0;
                pos_act <= 1'b1;
            end
            else if (pos_act)
            begin
                pos <= pos + 1'b1;
                if (pos == 4'(POS_NUM - 1))
                    pos_act <= 1'b0;
            end
            mul_vld     <= pos_act;
            o_sum_valid <= mul_vld;
        end
    end

    assign pos_m = pos[3:2];
    assign pos_n = pos[1:0];

    // weight (r, c) meets pixel (m + r, n + c) without kernel flip
    always_ff @(posedge clk)
    begin
        for (int r = 0; r < KD; r++)
        begin
            for (int c = 0; c < KD; c++)
                prod[r*KD + c] <= win[(pos_m + r) * ID + pos_n + c] * ker[r*KD + c];
        end
    end

    // adder tree with one register stage
    always_comb
    begin
        acc = '0;
        for (int k = 0; k < KER_PIX; k++)
            acc = acc + prod[k];   // sign extended to 20 bits
    end

    always_ff @(posedge clk)
    begin
        o_sum <= acc;
    end

endmodule

// ==== cad_pool_out.sv ====
`timescale 1ns/1ps
`include "cad_cfg.svh"

module cad_pool_out import cad_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  sum_t i_sum,
    input  logic i_sum_valid,
    output logic o_out_valid,
    output logic o_out_value
);

    localparam int CD       = `CAD_CONV_DIM;
    localparam int POS_NUM  = CD * CD;
    localparam int RES_NUM  = POS_NUM / 4;    // one per 2x2 block
    localparam int OUT_BITS = `CAD_OUT_BITS;

    sum_t       sums     [0:POS_NUM-1];
    sum_t       pool_max [0:RES_NUM-1];
    sum_t       res      [0:RES_NUM-1];
    logic [3:0] sum_cnt;
    logic       sums_done;
    logic [4:0] bit_cnt;
    logic [1:0] res_cnt;

    function automatic sum_t max2(input sum_t a, input sum_t b);
        return (a > b) ? a : b;   // signed compare
    endfunction

    // ------------------------------
    // 2x2 max pooling
    // ------------------------------
    // block q starts at row 2*(q/2), column 2*(q%2)
    always_comb
    begin
        for (int q = 0; q < RES_NUM; q++)
        begin
            pool_max[q] = max2(max2(sums[(q / 2) * 2 * CD + (q % 2) * 2],
                                    sums[(q / 2) * 2 * CD + (q % 2) * 2 + 1]),
                               max2(sums[(q / 2) * 2 * CD + (q % 2) * 2 + CD],
                                    sums[(q / 2) * 2 * CD + (q % 2) * 2 + CD + 1]));
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_sum_valid)
            sums[sum_cnt] <= i_sum;
        if (sums_done)
        begin
            for (int q = 0; q < RES_NUM; q++)
                res[q] <= pool_max[q];
        end
    end

    // ------------------------------
    // serial output
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sum_cnt     <= '0;
            sums_done   <= 1'b0;
            o_out_valid <= 1'b0;
            bit_cnt     <= '0;
            res_cnt     <= '0;
        end
        else
        begin
            if (i_sum_valid)
                sum_cnt <= sum_cnt + 1'b1;   // wraps for the next request
            sums_done <= i_sum_valid && (sum_cnt == 4'(POS_NUM - 1));
            if (sums_done)
            begin
                o_out_valid <= 1'b1;
                bit_cnt     <= '0;
                res_cnt     <= '0;
            end
            else if (o_out_valid)
            begin
                if (bit_cnt == 5'(OUT_BITS - 1))
                begin
                    bit_cnt <= '0;
                    res_cnt <= res_cnt + 1'b1;
                    if (res_cnt == 2'(RES_NUM - 1))
                        o_out_valid <= 1'b0;   // last bit of the last result
                end
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign o_out_value = o_out_valid & res[res_cnt][bit_cnt];   // lsb first

endmodule

// ==== cad_top.sv ====
`timescale 1ns/1ps

module cad_top import cad_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_in_valid,
    input  logic     i_in_valid2,
    input  pixel_t   i_matrix,
    input  mat_idx_t i_matrix_idx,
    output logic     o_out_valid,
    output logic     o_out_value
);

    logic conv_start;
    sum_t conv_sum;
    logic conv_sum_valid;

    // address, strobe and read data bundle
    cad_mem_if u_mem_if ();

    cad_ctrl u_ctrl
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_in_valid   (i_in_valid),
        .i_in_valid2  (i_in_valid2),
        .i_matrix_idx (i_matrix_idx),
        .o_conv_start (conv_start),
        .mem          (u_mem_if)
    );

    cad_store u_store
    (
        .clk      (clk),
        .i_matrix (i_matrix),   // write data straight from the port
        .mem      (u_mem_if)
    );

    cad_conv u_conv
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_conv_start (conv_start),
        .o_sum        (conv_sum),
        .o_sum_valid  (conv_sum_valid),
        .mem          (u_mem_if)
    );

    cad_pool_out u_pool_out
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_sum       (conv_sum),
        .i_sum_valid (conv_sum_valid),
        .o_out_valid (o_out_valid),
        .o_out_value (o_out_value)
    );

endmodule

// ==== tb_cad.sv ====
`timescale 1ns/1ps
`include "cad_cfg.svh"

module tb_cad;

    localparam int LOAD_LEN = `CAD_IMG_WORDS + `CAD_KER_WORDS;
    localparam int RES_BITS = 4 * `CAD_OUT_BITS;   // four pooled results per request
    localparam int MAX_REQ  = 32;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_valid2;
    logic [7:0] matrix;
    logic [3:0] matrix_idx;
    logic       out_valid;
    logic       out_value;

    // rules and requests from the stim file
    int    img_base [0:`CAD_NUM_MATS-1];
    int    img_row  [0:`CAD_NUM_MATS-1];
    int    img_col  [0:`CAD_NUM_MATS-1];
    int    ker_w    [0:`CAD_NUM_MATS-1][0:`CAD_KER_DIM-1];   // one weight per kernel row
    string req_name [0:MAX_REQ-1];
    int    req_img  [0:MAX_REQ-1];
    int    req_ker  [0:MAX_REQ-1];
    int    req_exp  [0:MAX_REQ-1][0:3];
    int    num_req;

    logic [7:0] stream [0:LOAD_LEN-1];
    bit   ok;
    bit   req_active;
    int   err_cnt;
    int   proto_errs;
    int   tests_run;
    int   tests_failed;
    int   cycle_cnt;
    int   cycle_limit;

    cad_top i_cad_top
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_in_valid   (in_valid),
        .i_in_valid2  (in_valid2),
        .i_matrix     (matrix),
        .i_matrix_idx (matrix_idx),
        .o_out_valid  (out_valid),
        .o_out_value  (out_value)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // checks and helpers
    // ------------------------------
    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (actual !== expected)
        begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic int total_errors();
        return err_cnt + proto_errs;
    endfunction

    task automatic read_stim(output bit ok_out);
        int    fd;
        int    code;
        int    idx;
        int    a, b, c, d, e, f;
        int    n_img;
        int    n_ker;
        string line;
        string tag;
        string name;
        ok_out  = 1'b0;
        n_img   = 0;
        n_ker   = 0;
        num_req = 0;
        fd = $fopen("cad_stim.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd))
        begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#")
            begin
                code = $sscanf(line, "%s", tag);
                if (tag == "img")
                begin
                    code = $sscanf(line, "%s %d %d %d %d", tag, idx, a, b, c);
                    if (code == 5 && idx >= 0 && idx < `CAD_NUM_MATS)
                    begin
                        img_base[idx] = a;
                        img_row[idx]  = b;
                        img_col[idx]  = c;
                        n_img++;
                    end
                end
                else if (tag == "ker")
                begin
                    code = $sscanf(line, "%s %d %d %d %d %d %d", tag, idx, a, b, c, d, e);
                    if (code == 7 && idx >= 0 && idx < `CAD_NUM_MATS)
                    begin
                        ker_w[idx][0] = a;
                        ker_w[idx][1] = b;
                        ker_w[idx][2] = c;
                        ker_w[idx][3] = d;
                        ker_w[idx][4] = e;
                        n_ker++;
                    end
                end
                else if (tag == "req" && num_req < MAX_REQ)
                begin
                    code = $sscanf(line, "%s %s %d %d %d %d %d %d",
                                   tag, name, a, b, c, d, e, f);
                    if (code == 8)
                    begin
                        req_name[num_req]   = name;
                        req_img[num_req]    = a;
                        req_ker[num_req]    = b;
                        req_exp[num_req][0] = c;
                        req_exp[num_req][1] = d;
                        req_exp[num_req][2] = e;
                        req_exp[num_req][3] = f;
                        num_req++;
                    end
                end
            end
        end
        $fclose(fd);
        ok_out = (n_img == `CAD_NUM_MATS) && (n_ker == `CAD_NUM_MATS) && (num_req > 0);
    endtask

    // image bytes first, then kernel bytes, both row-major
    task automatic build_stream();
        for (int n = 0; n < `CAD_NUM_MATS; n++)
        begin
            for (int r = 0; r < `CAD_IMG_DIM; r++)
            begin
                for (int c = 0; c < `CAD_IMG_DIM; c++)
                    stream[n*64 + r*8 + c] = 8'(img_base[n] + r*img_row[n] + c*img_col[n]);
            end
            for (int r = 0; r < `CAD_KER_DIM; r++)
            begin
                for (int c = 0; c < `CAD_KER_DIM; c++)
                    stream[`CAD_IMG_WORDS + n*25 + r*5 + c] = 8'(ker_w[n][r]);
            end
        end
    endtask

    task automatic send_load();
        for (int k = 0; k < LOAD_LEN; k++)
        begin
            @(posedge clk);
            in_valid <= 1'b1;
            matrix   <= stream[k];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        matrix   <= '0;
    endtask

    task automatic run_request(input int i);
        logic [RES_BITS-1:0] bits;
        logic signed [19:0]  got;
        int                  n;
        int                  errs_before;
        errs_before = total_errors();
        bits        = '0;
        req_active  = 1'b1;
        @(posedge clk);
        in_valid2  <= 1'b1;
        matrix_idx <= 4'(req_img[i]);   // image first
        @(posedge clk);
        matrix_idx <= 4'(req_ker[i]);
        @(posedge clk);
        in_valid2  <= 1'b0;
        matrix_idx <= '0;
        // wait for the first output bit
        @(negedge clk);
        while (out_valid !== 1'b1)
            @(negedge clk);
        n = 0;
        while (out_valid === 1'b1)
        begin
            if (n < RES_BITS)
                bits[n] = out_value;
            n++;
            @(negedge clk);
        end
        check_value({req_name[i], " valid length"}, RES_BITS, n);
        for (int q = 0; q < 4; q++)
        begin
            got = bits[q*`CAD_OUT_BITS +: `CAD_OUT_BITS];   // lsb came first
            check_value($sformatf("%s result %0d", req_name[i], q), req_exp[i][q], got);
        end
        req_active = 1'b0;
        tests_run++;
        if (total_errors() != errs_before)
            tests_failed++;
        $display("test %s: %s", req_name[i], (total_errors() == errs_before) ? "pass" : "fail");
    endtask

    // ------------------------------
    // monitors
    // ------------------------------
    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    always @(negedge clk)
    begin
        if (rst_n === 1'b1)
        begin
            if (out_valid === 1'b0 && out_value !== 1'b0)
            begin
                $display("o_out_value is not 0 while o_out_valid is low");
                proto_errs++;
            end
            if (!req_active && out_valid !== 1'b0)
            begin
                $display("o_out_valid is high with no request pending");
                proto_errs++;
            end
        end
    end

    initial
    begin
        @(posedge clk);
        while (cycle_cnt < cycle_limit)
            @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial
    begin
        int errs_before;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_valid2  = 1'b0;
        matrix     = '0;
        matrix_idx = '0;
        req_active = 1'b0;
        read_stim(ok);
        if (!ok)
        begin
            $display("could not read a complete cad_stim.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end
        else
        begin
            cycle_limit = 8 + LOAD_LEN + 40 + 200 * num_req;
            build_stream();
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            errs_before = total_errors();
            send_load();
            repeat (20) @(posedge clk);   // outputs must stay quiet here
            tests_run++;
            if (total_errors() != errs_before)
                tests_failed++;
            $display("test idle_load: %s", (total_errors() == errs_before) ? "pass" : "fail");
            for (int i = 0; i < num_req; i++)
                run_request(i);
            $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                     total_errors());
            if (total_errors() == 0)
                $display("*** TEST PASSED ***");
            else
                $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

// ==== cad_stim.txt ====
# img <idx> <base> <row step> <col step>   pixel(r,c) = base + r*row + c*col
# ker <idx> <w0..w4>   w<r> fills kernel row r; req <name> <img> <ker> <max0..max3>
img 0 1 2 1
img 1 10 -1 2
img 2 -20 3 1
img 3 5 0 3
img 4 0 1 1
img 5 50 -5 -2
img 6 -100 10 5
img 7 7 7 7
img 8 -3 -2 -4
img 9 100 -10 -3
img 10 0 0 0
img 11 12 4 -3
img 12 -60 5 9
img 13 20 2 2
img 14 64 -4 6
img 15 -5 3 -2
ker 0 1 1 1 1 1
ker 1 1 0 -1 0 1
ker 2 -1 -1 -1 -1 -1
ker 3 2 0 0 0 0
ker 4 0 0 1 0 0
ker 5 1 2 3 4 5
ker 6 -2 1 0 1 -2
ker 7 3 -1 2 -1 3
ker 8 0 0 0 0 0
ker 9 -5 -4 -3 -2 -1
ker 10 10 0 0 0 -10
ker 11 1 -1 1 -1 1
ker 12 4 4 4 4 4
ker 13 -3 2 -1 2 -3
ker 14 7 0 0 0 0
ker 15 1 1 -2 1 1
req pos_i0_k0 0 0 250 300 350 400
req neg_i0_k2 0 2 -175 -225 -275 -325
req last_i15_k15 15 15 0 -40 60 20
req mix_i6_k9 6 9 5750 5000 4250 3500
req mix_i14_k5 14 5 5350 6250 4750 5650
req mix_i3_k13 3 13 -165 -255 -165 -255
req mix_i9_k10 9 10 2000 2000 2000 2000
req mix_i12_k7 12 7 -540 0 -240 300
req mix_i5_k11 5 11 180 160 130 110
req mix_i7_k12 7 12 4900 6300 6300 7700
req zero_i10_k14 10 14 0 0 0 0
req mix_i0_k15 0 15 100 120 140 160
req mix_i15_k0 15 0 0 -100 150 50

// ==== verilog.f ====
+incdir+.
cad_pkg.sv
cad_mem_if.sv
cad_ctrl.sv
cad_store.sv
cad_conv.sv
cad_pool_out.sv
cad_top.sv
tb_cad.sv
